/* common/md_consts.svh */
/*
 * width defines for the iterative multiply/divide unit
 * data word, extended adder operand and iteration counter
 */

`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// architectural data width
`define MD_XLEN 32

// one extra bit carries the sign into the shared adder
`define MD_EXTW 33

// counts the remaining bit positions of an operation
`define MD_CNTW 5

`endif

/* common/md_pkg.sv */
/*
 * types of the multiply/divide unit
 * operator encoding, request and response structs, sequencer states
 */

`default_nettype none

`include "md_consts.svh"

package md_pkg;

  // MULH covers MULH, MULHSU and MULHU through signed_mode
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // signed_mode[0] marks op_a signed, signed_mode[1] marks op_b signed
  typedef struct packed {
    md_op_e              op;
    logic [1:0]          signed_mode;
    logic [`MD_XLEN-1:0] op_a;
    logic [`MD_XLEN-1:0] op_b;
  } md_req_t;

  typedef struct packed {
    logic [`MD_XLEN-1:0] result;
  } md_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } md_state_e;

endpackage

`default_nettype wire

/* hw/multdiv/md_arith_share.sv */
/*
 * shared arithmetic for the multdiv sequencer
 * 33-bit adder with zero detect and the 34-bit intermediate register
 */

`default_nettype none

`include "md_consts.svh"

module md_arith_share (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`MD_EXTW-1:0] operand_a_i,
  input  logic [`MD_EXTW-1:0] operand_b_i,
  input  logic [`MD_EXTW:0]   imd_val_d_i,
  input  logic                imd_val_we_i,
  output logic [`MD_EXTW:0]   adder_ext_o,
  output logic [`MD_XLEN-1:0] adder_o,
  output logic                adder_zero_o,
  output logic [`MD_EXTW:0]   imd_val_q_o
);

  logic [`MD_EXTW:0] imd_val_q;

  // full sum keeps the carry out
  assign adder_ext_o = {1'b0, operand_a_i} + {1'b0, operand_b_i};

  // bit 0 is the carry-in slot, so the word sits one position up
  assign adder_o = adder_ext_o[`MD_XLEN:1];

  // zero divisor check
  assign adder_zero_o = (adder_o == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd_val_q <= '0;
    end else if (imd_val_we_i) begin
      imd_val_q <= imd_val_d_i;
    end
  end

  assign imd_val_q_o = imd_val_q;

endmodule

`default_nettype wire

/* hw/multdiv/md_slow_seq.sv */
/*
 * serial multiply/divide sequencer
 * Baugh-Wooley multiplication and restoring long division, both
 * running through the shared adder and intermediate register
 */

`default_nettype none

`include "md_consts.svh"

module md_slow_seq (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                mult_en_i,
  input  logic                div_en_i,
  input  logic                mult_sel_i,
  input  logic                div_sel_i,
  input  md_pkg::md_op_e      operator_i,
  input  logic [1:0]          signed_mode_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  input  logic [`MD_EXTW:0]   adder_ext_i,
  input  logic [`MD_XLEN-1:0] adder_i,
  input  logic                adder_zero_i,
  input  logic [`MD_EXTW:0]   imd_val_q_i,
  input  logic                rsp_ready_i,
  output logic [`MD_EXTW-1:0] alu_operand_a_o,
  output logic [`MD_EXTW-1:0] alu_operand_b_o,
  output logic [`MD_EXTW:0]   imd_val_d_o,
  output logic                imd_val_we_o,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o
);

  import md_pkg::*;

  md_state_e           state_q, state_d;
  logic [`MD_CNTW-1:0] cnt_q, cnt_d, cnt_m1;
  logic [`MD_EXTW-1:0] accum_q, accum_d;
  logic [`MD_EXTW-1:0] sum_lo, sum_hi;
  logic [`MD_EXTW-1:0] op_a_shift_q, op_a_shift_d;
  logic [`MD_EXTW-1:0] op_b_shift_q, op_b_shift_d;
  logic [`MD_EXTW-1:0] op_a_ext, op_b_ext;
  logic [`MD_EXTW-1:0] one_shift;
  logic [`MD_EXTW-1:0] pp, pp_last;
  logic [`MD_EXTW-1:0] next_rem, next_quot;
  logic [`MD_XLEN-1:0] b_rep;
  logic [`MD_XLEN-1:0] numer_q, numer_d;
  logic                sign_a, sign_b;
  logic                ge;
  logic                div_neg, rem_neg;
  logic                hold;

  // raw sum and sum shifted right by one
  assign sum_lo = adder_ext_i[`MD_EXTW-1:0];
  assign sum_hi = adder_ext_i[`MD_EXTW:1];

  // accumulator lives in the shared intermediate register
  assign accum_q      = imd_val_q_i[`MD_EXTW-1:0];
  assign imd_val_d_o  = {1'b0, accum_d};
  assign imd_val_we_o = (mult_en_i | div_en_i) & ~hold;

  assign sign_a   = op_a_i[`MD_XLEN-1] & signed_mode_i[0];
  assign sign_b   = op_b_i[`MD_XLEN-1] & signed_mode_i[1];
  assign op_a_ext = {sign_a, op_a_i};
  assign op_b_ext = {sign_b, op_b_i};
  assign div_neg  = sign_a ^ sign_b;
  assign rem_neg  = sign_a;

  // Baugh-Wooley partial products
  // the sign row of the last product is inverted the other way
  assign b_rep   = {`MD_XLEN{op_b_shift_q[0]}};
  assign pp      = {~(op_a_shift_q[`MD_XLEN] & op_b_shift_q[0]),
                    op_a_shift_q[`MD_XLEN-1:0] & b_rep};
  assign pp_last = {op_a_shift_q[`MD_XLEN] & op_b_shift_q[0],
                    ~(op_a_shift_q[`MD_XLEN-1:0] & b_rep)};

  // adder holds remainder - divisor during COMP and LAST
  assign ge = ((accum_q[`MD_XLEN-1] ^ op_b_shift_q[`MD_XLEN-1]) == 1'b0) ?
              ~sum_hi[`MD_XLEN-1] : accum_q[`MD_XLEN-1];

  assign cnt_m1    = cnt_q - `MD_CNTW'(1);
  assign one_shift = `MD_EXTW'(1) << cnt_q;
  assign next_rem  = ge ? sum_hi : accum_q;
  assign next_quot = ge ? (op_a_shift_q | one_shift) : op_a_shift_q;

  assign result_o = div_sel_i ? accum_q[`MD_XLEN-1:0] : sum_lo[`MD_XLEN-1:0];
  assign valid_o  = (state_q == FINISH) | ((state_q == LAST) & mult_sel_i);

  // adder operand selection
  always_comb begin
    alu_operand_a_o = accum_q;
    alu_operand_b_o = pp;
    unique case (operator_i)
      MD_OP_MULL: alu_operand_b_o = pp;
      MD_OP_MULH: alu_operand_b_o = (state_q == LAST) ? pp_last : pp;
      default: begin
        unique case (state_q)
          // 0 - b, zero only for a zero divisor
          IDLE, ABS_B: begin
            alu_operand_a_o = `MD_EXTW'(1);
            alu_operand_b_o = {~op_b_i, 1'b1};
          end
          ABS_A: begin
            alu_operand_a_o = `MD_EXTW'(1);
            alu_operand_b_o = {~op_a_i, 1'b1};
          end
          CHANGE_SIGN: begin
            alu_operand_a_o = `MD_EXTW'(1);
            alu_operand_b_o = {~accum_q[`MD_XLEN-1:0], 1'b1};
          end
          default: begin
            alu_operand_a_o = {accum_q[`MD_XLEN-1:0], 1'b1};
            alu_operand_b_o = {~op_b_shift_q[`MD_XLEN-1:0], 1'b1};
          end
        endcase
      end
    endcase
  end

  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    accum_d      = accum_q;
    op_a_shift_d = op_a_shift_q;
    op_b_shift_d = op_b_shift_q;
    numer_d      = numer_q;
    hold         = 1'b0;
    if (mult_sel_i || div_sel_i) begin
      unique case (state_q)
        IDLE: begin
          unique case (operator_i)
            MD_OP_MULL: begin
              op_a_shift_d = op_a_ext << 1;
              accum_d      = {~(op_a_ext[`MD_XLEN] & op_b_i[0]),
                              op_a_ext[`MD_XLEN-1:0] & {`MD_XLEN{op_b_i[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              state_d      = ((op_b_ext >> 1) == '0) ? LAST : COMP;
            end
            MD_OP_MULH: begin
              op_a_shift_d = op_a_ext;
              accum_d      = {1'b1, ~(op_a_ext[`MD_XLEN] & op_b_i[0]),
                              op_a_ext[`MD_XLEN-1:1] & {(`MD_XLEN-1){op_b_i[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              state_d      = COMP;
            end
            // zero divisor results are loaded up front
            MD_OP_DIV: begin
              accum_d = '1;
              state_d = adder_zero_i ? FINISH : ABS_A;
            end
            default: begin
              accum_d = op_a_ext;
              state_d = adder_zero_i ? FINISH : ABS_A;
            end
          endcase
          cnt_d = `MD_CNTW'(`MD_XLEN - 1);
        end
        ABS_A: begin
          op_a_shift_d = '0;
          numer_d      = sign_a ? adder_i : op_a_i;
          state_d      = ABS_B;
        end
        ABS_B: begin
          accum_d      = {{`MD_XLEN{1'b0}}, numer_q[`MD_XLEN-1]};
          op_b_shift_d = {1'b0, (sign_b ? adder_i : op_b_i)};
          state_d      = COMP;
        end
        COMP: begin
          cnt_d = cnt_m1;
          unique case (operator_i)
            MD_OP_MULL: begin
              accum_d      = sum_lo;
              op_a_shift_d = op_a_shift_q << 1;
              op_b_shift_d = op_b_shift_q >> 1;
              // stop once no multiplier bits are left
              state_d      = ((op_b_shift_q >> 1) == '0) ? LAST : COMP;
            end
            MD_OP_MULH: begin
              accum_d      = sum_hi;
              op_b_shift_d = op_b_shift_q >> 1;
              state_d      = (cnt_q == `MD_CNTW'(1)) ? LAST : COMP;
            end
            default: begin
              accum_d      = {next_rem[`MD_XLEN-1:0], numer_q[cnt_m1]};
              op_a_shift_d = next_quot;
              state_d      = (cnt_q == `MD_CNTW'(1)) ? LAST : COMP;
            end
          endcase
        end
        LAST: begin
          unique case (operator_i)
            MD_OP_MULL, MD_OP_MULH: begin
              accum_d = sum_lo;
              state_d = IDLE;
              hold    = ~rsp_ready_i;
            end
            MD_OP_DIV: begin
              accum_d = next_quot;
              state_d = CHANGE_SIGN;
            end
            default: begin
              accum_d = {1'b0, next_rem[`MD_XLEN-1:0]};
              state_d = CHANGE_SIGN;
            end
          endcase
        end
        CHANGE_SIGN: begin
          state_d = FINISH;
          if (operator_i == MD_OP_DIV) begin
            accum_d = div_neg ? {1'b0, adder_i} : accum_q;
          end else begin
            accum_d = rem_neg ? {1'b0, adder_i} : accum_q;
          end
        end
        FINISH: begin
          state_d = IDLE;
          hold    = ~rsp_ready_i;
        end
        default: state_d = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if ((mult_en_i || div_en_i) && !hold) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // operand shifters and the absolute dividend
  always_ff @(posedge clk_i) begin
    if ((mult_en_i || div_en_i) && !hold) begin
      op_a_shift_q <= op_a_shift_d;
      op_b_shift_q <= op_b_shift_d;
      numer_q      <= numer_d;
    end
  end

endmodule

`default_nettype wire

/* hw/md_issue.sv */
/*
 * request issue for the multiply/divide unit
 * latches one request, decodes selects and enables, tracks busy
 */

`default_nettype none

`include "md_consts.svh"

module md_issue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  md_pkg::md_req_t     req_i,
  input  logic                seq_valid_i,
  input  logic                rsp_ready_i,
  output logic                busy_o,
  output md_pkg::md_op_e      operator_o,
  output logic [1:0]          signed_mode_o,
  output logic [`MD_XLEN-1:0] op_a_o,
  output logic [`MD_XLEN-1:0] op_b_o,
  output logic                mult_sel_o,
  output logic                div_sel_o,
  output logic                mult_en_o,
  output logic                div_en_o
);

  import md_pkg::*;

  logic                busy_q;
  logic                accept;
  logic                done;
  md_op_e              op_q;
  logic [1:0]          signed_mode_q;
  logic [`MD_XLEN-1:0] op_a_q;
  logic [`MD_XLEN-1:0] op_b_q;

  // only one operation in flight
  assign accept = req_valid_i & ~busy_q;
  // result handed over to the consumer
  assign done   = seq_valid_i & rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      op_q   <= MD_OP_MULL;
    end else if (accept) begin
      busy_q <= 1'b1;
      op_q   <= req_i.op;
    end else if (done) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      signed_mode_q <= req_i.signed_mode;
      op_a_q        <= req_i.op_a;
      op_b_q        <= req_i.op_b;
    end
  end

  // static selects follow the latched operator
  assign mult_sel_o = (op_q == MD_OP_MULL) | (op_q == MD_OP_MULH);
  assign div_sel_o  = (op_q == MD_OP_DIV) | (op_q == MD_OP_REM);

  // enables only while an operation is running
  assign mult_en_o = busy_q & mult_sel_o;
  assign div_en_o  = busy_q & div_sel_o;

  assign busy_o        = busy_q;
  assign operator_o    = op_q;
  assign signed_mode_o = signed_mode_q;
  assign op_a_o        = op_a_q;
  assign op_b_o        = op_b_q;

endmodule

`default_nettype wire

/* hw/md_unit_top.sv */
/*
 * multiply/divide unit top level
 * issue block, serial sequencer and shared arithmetic
 */

`default_nettype none

`include "md_consts.svh"

module md_unit_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  input  md_pkg::md_req_t req_i,
  output logic            busy_o,
  output logic            rsp_valid_o,
  output md_pkg::md_rsp_t rsp_o,
  input  logic            rsp_ready_i
);

  import md_pkg::*;

  md_op_e              operator;
  logic [1:0]          signed_mode;
  logic [`MD_XLEN-1:0] op_a, op_b;
  logic                mult_sel, div_sel, mult_en, div_en;
  logic [`MD_EXTW-1:0] alu_a, alu_b;
  logic [`MD_EXTW:0]   adder_ext, imd_d, imd_q;
  logic [`MD_XLEN-1:0] adder, seq_result;
  logic                adder_zero, imd_we, seq_valid;

  md_issue i_md_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .seq_valid_i   (seq_valid),
    .rsp_ready_i   (rsp_ready_i),
    .busy_o        (busy_o),
    .operator_o    (operator),
    .signed_mode_o (signed_mode),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .mult_sel_o    (mult_sel),
    .div_sel_o     (div_sel),
    .mult_en_o     (mult_en),
    .div_en_o      (div_en)
  );

  md_slow_seq i_md_slow_seq (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mult_en_i       (mult_en),
    .div_en_i        (div_en),
    .mult_sel_i      (mult_sel),
    .div_sel_i       (div_sel),
    .operator_i      (operator),
    .signed_mode_i   (signed_mode),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .adder_ext_i     (adder_ext),
    .adder_i         (adder),
    .adder_zero_i    (adder_zero),
    .imd_val_q_i     (imd_q),
    .rsp_ready_i     (rsp_ready_i),
    .alu_operand_a_o (alu_a),
    .alu_operand_b_o (alu_b),
    .imd_val_d_o     (imd_d),
    .imd_val_we_o    (imd_we),
    .result_o        (seq_result),
    .valid_o         (seq_valid)
  );

  md_arith_share i_md_arith_share (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (alu_a),
    .operand_b_i  (alu_b),
    .imd_val_d_i  (imd_d),
    .imd_val_we_i (imd_we),
    .adder_ext_o  (adder_ext),
    .adder_o      (adder),
    .adder_zero_o (adder_zero),
    .imd_val_q_o  (imd_q)
  );

  assign rsp_valid_o = seq_valid;
  assign rsp_o       = '{result: seq_result};

endmodule

`default_nettype wire

/* dv/md_checker.sv */
/*
 * response checker for the multiply/divide unit
 * records accepted requests, models RISC-V M results, checks back-pressure
 */

`default_nettype none

`include "md_consts.svh"

module md_checker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  md_pkg::md_req_t     req_i,
  input  logic                busy_i,
  input  logic                tbl_vld_i,
  input  logic [`MD_XLEN-1:0] tbl_exp_i,
  input  logic                rsp_valid_i,
  input  logic                rsp_ready_i,
  input  md_pkg::md_rsp_t     rsp_i,
  output int unsigned         err_cnt_o,
  output int unsigned         pend_o
);

  import md_pkg::*;

  logic [`MD_XLEN-1:0] model_q[$];
  logic [`MD_XLEN:0]   table_q[$];
  logic [`MD_XLEN-1:0] want;
  logic [`MD_XLEN:0]   tref;
  logic                stall_q;
  logic [`MD_XLEN-1:0] held_q;

  // product of sign or zero extended operands
  // division truncates toward zero
  function automatic logic [`MD_XLEN-1:0] model_result(md_req_t r);
    logic [2*`MD_XLEN-1:0] xa, xb, prod;
    logic signed [`MD_XLEN+1:0] da, db, quot, rem;
    xa   = r.signed_mode[0] ? {{`MD_XLEN{r.op_a[`MD_XLEN-1]}}, r.op_a} : {`MD_XLEN'(0), r.op_a};
    xb   = r.signed_mode[1] ? {{`MD_XLEN{r.op_b[`MD_XLEN-1]}}, r.op_b} : {`MD_XLEN'(0), r.op_b};
    prod = xa * xb;
    da   = r.signed_mode[0] ? {{2{r.op_a[`MD_XLEN-1]}}, r.op_a} : {2'b00, r.op_a};
    db   = r.signed_mode[1] ? {{2{r.op_b[`MD_XLEN-1]}}, r.op_b} : {2'b00, r.op_b};
    if (r.op == MD_OP_MULL) return prod[`MD_XLEN-1:0];
    if (r.op == MD_OP_MULH) return prod[2*`MD_XLEN-1:`MD_XLEN];
    // divide by zero gives all ones or the dividend
    if (r.op_b == '0) return (r.op == MD_OP_DIV) ? '1 : r.op_a;
    quot = da / db;
    rem  = da % db;
    return (r.op == MD_OP_DIV) ? quot[`MD_XLEN-1:0] : rem[`MD_XLEN-1:0];
  endfunction

  // sampled on the falling edge, away from input and register updates
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      err_cnt_o = 0;
      pend_o    = 0;
      stall_q   = 1'b0;
    end else begin
      if (req_valid_i && !busy_i) begin
        model_q.push_back(model_result(req_i));
        table_q.push_back({tbl_vld_i, tbl_exp_i});
      end
      // a stalled response must stay valid and unchanged
      if (stall_q && rsp_valid_i !== 1'b1) begin
        $display("MISMATCH rsp_valid_o during stall: got %h expected 1", rsp_valid_i);
        err_cnt_o++;
      end
      if (stall_q && rsp_i.result !== held_q) begin
        $display("MISMATCH rsp_o.result during stall: got %h expected %h",
                 rsp_i.result, held_q);
        err_cnt_o++;
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (model_q.size() == 0) begin
          $display("response seen without an accepted request");
          err_cnt_o++;
        end else begin
          want = model_q.pop_front();
          tref = table_q.pop_front();
          if (rsp_i.result !== want) begin
            $display("MISMATCH rsp_o.result: got %h expected %h", rsp_i.result, want);
            err_cnt_o++;
          end
          if (tref[`MD_XLEN] && rsp_i.result !== tref[`MD_XLEN-1:0]) begin
            $display("MISMATCH rsp_o.result against table: got %h expected %h",
                     rsp_i.result, tref[`MD_XLEN-1:0]);
            err_cnt_o++;
          end
        end
      end
      stall_q = rsp_valid_i && !rsp_ready_i;
      held_q  = rsp_i.result;
      pend_o  = model_q.size();
    end
  end

endmodule

`default_nettype wire

/* dv/tb_md_unit.sv */
/*
 * testbench for the multiply/divide unit
 * clock, reset, directed and random stimulus table, drive loop
 */

`default_nettype none

`include "md_consts.svh"

module tb_md_unit;

  import md_pkg::*;

  localparam int unsigned NDIR = 27;
  localparam int unsigned NRND = 12;
  localparam int unsigned NROW = NDIR + NRND;
  localparam int unsigned TMO  = 100;
  localparam int unsigned DRV  = 2;

  // one stimulus row
  // stall counts cycles with rsp_ready_i held low
  typedef struct packed {
    md_op_e              op;
    logic [1:0]          sm;
    logic [`MD_XLEN-1:0] a;
    logic [`MD_XLEN-1:0] b;
    logic [3:0]          stall;
    logic                has_exp;
    logic [`MD_XLEN-1:0] exp;
  } row_t;

  logic                clk_i;
  logic                rst_ni;
  logic                req_valid_i;
  md_req_t             req_i;
  logic                busy_o;
  logic                rsp_valid_o;
  md_rsp_t             rsp_o;
  logic                rsp_ready_i;
  logic                tbl_vld;
  logic [`MD_XLEN-1:0] tbl_exp;
  int unsigned         chk_err;
  int unsigned         pend;
  int unsigned         tb_err;
  int unsigned         seed;
  logic                timed_out;
  row_t                tbl [0:NROW-1];

  md_unit_top i_md_unit_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

  md_checker i_md_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_i      (busy_o),
    .tbl_vld_i   (tbl_vld),
    .tbl_exp_i   (tbl_exp),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o),
    .err_cnt_o   (chk_err),
    .pend_o      (pend)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic row_t make_row(md_op_e op, logic [1:0] sm, logic [`MD_XLEN-1:0] a,
                                    logic [`MD_XLEN-1:0] b, logic [3:0] stall,
                                    logic [`MD_XLEN-1:0] exp);
    row_t r;
    r = '{op: op, sm: sm, a: a, b: b, stall: stall, has_exp: 1'b1, exp: exp};
    return r;
  endfunction

  task automatic fill_table();
    int unsigned i;
    md_op_e      op;
    logic [1:0]  sm;
    logic [`MD_XLEN-1:0] b;
    tbl[0]  = make_row(MD_OP_MULL, 2'b11, 32'h0000_0007, 32'h0000_0006, 4'd0, 32'h0000_002A);
    tbl[1]  = make_row(MD_OP_MULL, 2'b11, 32'hFFFF_FFFD, 32'h0000_0005, 4'd0, 32'hFFFF_FFF1);
    tbl[2]  = make_row(MD_OP_MULL, 2'b11, 32'h1234_5678, 32'h0000_0000, 4'd0, 32'h0000_0000);
    tbl[3]  = make_row(MD_OP_MULL, 2'b11, 32'h1234_5678, 32'h0000_0001, 4'd0, 32'h1234_5678);
    tbl[4]  = make_row(MD_OP_MULL, 2'b11, 32'h0000_0005, 32'hFFFF_FFFE, 4'd2, 32'hFFFF_FFF6);
    tbl[5]  = make_row(MD_OP_MULL, 2'b00, 32'h0000_1234, 32'h0000_0100, 4'd5, 32'h0012_3400);
    tbl[6]  = make_row(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 4'd0, 32'h4000_0000);
    tbl[7]  = make_row(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 32'h0000_0000);
    tbl[8]  = make_row(MD_OP_MULH, 2'b01, 32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 32'h8000_0000);
    tbl[9]  = make_row(MD_OP_MULH, 2'b00, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 4'd3, 32'hFFFF_FFFE);
    tbl[10] = make_row(MD_OP_MULH, 2'b01, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 4'd0, 32'hFFFF_FFFF);
    tbl[11] = make_row(MD_OP_MULH, 2'b00, 32'h8000_0000, 32'h8000_0000, 4'd0, 32'h4000_0000);
    tbl[12] = make_row(MD_OP_DIV,  2'b11, 32'h0000_0014, 32'hFFFF_FFFA, 4'd0, 32'hFFFF_FFFD);
    tbl[13] = make_row(MD_OP_REM,  2'b11, 32'hFFFF_FFEC, 32'h0000_0006, 4'd0, 32'hFFFF_FFFE);
    tbl[14] = make_row(MD_OP_DIV,  2'b00, 32'hFFFF_FFFF, 32'h0000_0010, 4'd0, 32'h0FFF_FFFF);
    tbl[15] = make_row(MD_OP_REM,  2'b00, 32'hFFFF_FFFF, 32'h0000_0010, 4'd0, 32'h0000_000F);
    // signed overflow
    tbl[16] = make_row(MD_OP_DIV,  2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 32'h8000_0000);
    tbl[17] = make_row(MD_OP_REM,  2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 32'h0000_0000);
    tbl[18] = make_row(MD_OP_DIV,  2'b00, 32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 32'h0000_0000);
    tbl[19] = make_row(MD_OP_REM,  2'b00, 32'h8000_0000, 32'hFFFF_FFFF, 4'd0, 32'h8000_0000);
    // zero divisor
    tbl[20] = make_row(MD_OP_DIV,  2'b11, 32'h1234_5678, 32'h0000_0000, 4'd0, 32'hFFFF_FFFF);
    tbl[21] = make_row(MD_OP_REM,  2'b11, 32'h1234_5678, 32'h0000_0000, 4'd0, 32'h1234_5678);
    tbl[22] = make_row(MD_OP_DIV,  2'b00, 32'h0000_0064, 32'h0000_0000, 4'd4, 32'hFFFF_FFFF);
    tbl[23] = make_row(MD_OP_REM,  2'b00, 32'hFFFF_FFF0, 32'h0000_0000, 4'd0, 32'hFFFF_FFF0);
    tbl[24] = make_row(MD_OP_DIV,  2'b11, 32'hFFFF_FF9C, 32'h0000_0007, 4'd6, 32'hFFFF_FFF2);
    tbl[25] = make_row(MD_OP_REM,  2'b11, 32'hFFFF_FF9C, 32'h0000_0007, 4'd3, 32'hFFFF_FFFE);
    tbl[26] = make_row(MD_OP_MULH, 2'b11, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 4'd0, 32'h0000_0000);
    // random rows are checked against the model only
    for (i = NDIR; i < NROW; i++) begin
      op = md_op_e'($urandom % 4);
      sm = 2'($urandom % 4);
      if (op == MD_OP_DIV || op == MD_OP_REM) begin
        sm = sm[0] ? 2'b11 : 2'b00;
      end
      b = ($urandom % 2) ? `MD_XLEN'($urandom % 1000) : `MD_XLEN'($urandom);
      tbl[i] = make_row(op, sm, `MD_XLEN'($urandom), b, 4'($urandom % 3), '0);
      tbl[i].has_exp = 1'b0;
    end
  endtask

  task automatic wait_rsp_valid(output logic ok);
    int unsigned n;
    n = 0;
    while (rsp_valid_o !== 1'b1 && n < TMO) begin
      @(posedge clk_i);
      #DRV;
      n++;
    end
    ok = (rsp_valid_o === 1'b1);
    if (!ok) begin
      $display("timeout: rsp_valid_o did not rise within %0d cycles", TMO);
      tb_err++;
    end
  endtask

  task automatic wait_idle(output logic ok);
    int unsigned n;
    n = 0;
    while (busy_o !== 1'b0 && n < TMO) begin
      @(posedge clk_i);
      #DRV;
      n++;
    end
    ok = (busy_o === 1'b0);
    if (!ok) begin
      $display("timeout: busy_o did not fall within %0d cycles", TMO);
      tb_err++;
    end
  endtask

  task automatic apply_row(input row_t r, output logic ok);
    int unsigned k;
    wait_idle(ok);
    if (!ok) return;
    rsp_ready_i = (r.stall == 0);
    req_i       = '{op: r.op, signed_mode: r.sm, op_a: r.a, op_b: r.b};
    tbl_vld     = r.has_exp;
    tbl_exp     = r.exp;
    req_valid_i = 1'b1;
    @(posedge clk_i);
    #DRV;
    if (busy_o !== 1'b1) begin
      $display("MISMATCH busy_o after request: got %h expected 1", busy_o);
      tb_err++;
    end
    // a second strobe while busy has to be dropped
    req_i.op_a = ~r.a;
    tbl_vld    = 1'b0;
    @(posedge clk_i);
    #DRV;
    req_valid_i = 1'b0;
    wait_rsp_valid(ok);
    if (!ok) return;
    for (k = 0; k < r.stall; k++) begin
      req_valid_i = (k == 0);
      @(posedge clk_i);
      #DRV;
    end
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    wait_idle(ok);
  endtask

  initial begin
    int unsigned i;
    logic        ok;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    tbl_vld     = 1'b0;
    tbl_exp     = '0;
    tb_err      = 0;
    timed_out   = 1'b0;
    seed        = $urandom(6);
    fill_table();
    repeat (4) @(posedge clk_i);
    #DRV;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #DRV;
    if (busy_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
      $display("MISMATCH busy_o/rsp_valid_o after reset: got %h/%h expected 0/0",
               busy_o, rsp_valid_o);
      tb_err++;
    end
    for (i = 0; i < NROW && !timed_out; i++) begin
      apply_row(tbl[i], ok);
      timed_out = ~ok;
    end
    repeat (4) @(posedge clk_i);
    if (pend != 0) begin
      $display("%0d accepted requests never got a response", pend);
      tb_err++;
    end
    $display("errors: checker %0d, testbench %0d", chk_err, tb_err);
    if (timed_out || chk_err != 0 || tb_err != 0) begin
      $display("TESTS FAILED");
    end else begin
      $display("TESTS PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* md_unit_top.f */
+incdir+common
common/md_pkg.sv
hw/multdiv/md_arith_share.sv
hw/multdiv/md_slow_seq.sv
hw/md_issue.sv
hw/md_unit_top.sv
dv/md_checker.sv
dv/tb_md_unit.sv

/* Bender.yml */
package:
  name: md_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/md_pkg.sv
      - hw/multdiv/md_arith_share.sv
      - hw/multdiv/md_slow_seq.sv
      - hw/md_issue.sv
      - hw/md_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/md_checker.sv
      - dv/tb_md_unit.sv
